// ==== Bender.yml ====
package:
  name: video_gen

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/video_pkg.sv
      - verilog/video_reg_decode.sv
      - verilog/video_timing_exec.sv
      - verilog/video_reg_result.sv
      - verilog/video_gen.sv
  - target: simulation
    include_dirs:
      - verilog
    files:
      - sim/video_gen_properties.sv
      - sim/video_gen_tb.sv

// ==== sim/video_gen_properties.sv ====
// video generator timing properties
`default_nettype none
`timescale 1ns/1ps

module video_gen_properties (
    input wire logic clk,
    input wire logic reset_i,
    input wire logic v_blank_i,
    input wire logic video_intr_i,
    input wire logic pf_line_addr_set_i,
    input wire logic dv_de_i,
    input wire logic hsync_i,
    input wire logic mem_fetch_i
);

    intr_one_cycle: assert property (@(posedge clk) disable iff (reset_i)
        video_intr_i |=> !video_intr_i)
        else $error("video_intr_o high for two cycles in a row");

    line_addr_set_one_cycle: assert property (@(posedge clk) disable iff (reset_i)
        pf_line_addr_set_i |=> !pf_line_addr_set_i)
        else $error("pf_line_addr_set_o high for two cycles in a row");

    // sync sits in the offscreen part of the line
    de_not_in_hsync: assert property (@(posedge clk) disable iff (reset_i)
        dv_de_i |-> !hsync_i)
        else $error("dv_de_o high during hsync_o");

    // fetch window only opens on visible lines
    fetch_on_visible_lines: assert property (@(posedge clk) disable iff (reset_i)
        mem_fetch_i |-> !v_blank_i)
        else $error("mem_fetch_o high on a vertically blanked line");

endmodule

// line address strobe lives in decode, so attach at the top level
bind video_gen video_gen_properties props (
    .clk                (clk),
    .reset_i            (reset_i),
    .v_blank_i          (v_blank_o),
    .video_intr_i       (video_intr_o),
    .pf_line_addr_set_i (pf_line_addr_set_o),
    .dv_de_i            (dv_de_o),
    .hsync_i            (hsync_o),
    .mem_fetch_i        (mem_fetch_o)
);

`default_nettype wire

// ==== sim/video_gen_tb.sv ====
// video generator testbench
`include "video_defines.svh"
`default_nettype none
`timescale 1ns/1ps

module video_gen_tb;

    localparam int TABLE_LEN = 13;
    localparam int FRAME_CYCLES = 800 * 525;
    localparam int WATCHDOG_CYCLES = 3 * FRAME_CYCLES + TABLE_LEN * 4 + 4000;

    logic        clk = 1'b0;
    logic        reset_i;
    logic        reg_wr_en_i;
    logic [5:0]  reg_num_i;
    logic [15:0] reg_data_i;
    logic [15:0] reg_data_o;
    logic        hsync_o, vsync_o, dv_de_o, h_blank_o, v_blank_o;
    logic        mem_fetch_o, video_intr_o, pf_blank_o, pf_bitmap_o, pf_line_addr_set_o;
    logic [7:0]  border_color_o, pf_colorbase_o;
    logic [1:0]  pf_bpp_o, pf_h_repeat_o, pf_v_repeat_o;
    logic [15:0] pf_start_addr_o, pf_line_len_o, pf_line_addr_o;
    logic [4:0]  pf_fine_hscroll_o;
    logic [5:0]  pf_fine_vscroll_o;

    // register number and mask of the bits that read back
    logic [21:0] table_entries [TABLE_LEN] = '{
        {`XR_VID_CTRL, 16'h00FF},     {`XR_VID_LEFT, 16'h03FF},
        {`XR_VID_RIGHT, 16'h03FF},    {`XR_VID_INTR, 16'h0000},
        {`XR_PA_GFX_CTRL, 16'hFFFF},  {`XR_PA_DISP_ADDR, 16'hFFFF},
        {`XR_PA_LINE_LEN, 16'hFFFF},  {`XR_PA_HV_SCROLL, 16'h1F3F},
        {`XR_PA_LINE_ADDR, 16'hFFFF}, {6'h01, 16'h0000},
        {6'h17, 16'h0000},            {6'h2C, 16'h0000},
        {6'h3F, 16'h0000}
    };

    logic [31:0] rng = 32'd32;
    logic [5:0]  num;
    logic [15:0] mask, data;
    int          sets_before;
    int          addr_sets = 0;
    bit          measuring = 1'b0;
    int          cycle = 0;
    int          hs_at = -1, hs_len = -1, vs_at = -1, vs_len = -1, intr_at = -1;
    int          de_len = -1, fetch_len = -1, de_lines = 0, fetch_lines = 0;
    int          vs_rises = 0, intr_rises = 0, frames_checked = 0;
    bit          frame_ok = 1'b0;
    logic        hs_q = 1'b0, vs_q = 1'b0, de_q = 1'b0, fetch_q = 1'b0;
    logic        vb_q = 1'b0, intr_q = 1'b0, hb_q = 1'b0;

    video_gen dut (.*);

    always #2 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        if (actual !== expected) begin
            $display("FAILED %s: got 0x%h, expected 0x%h", name, actual, expected);
            $display("Simulation FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic write_reg(input logic [5:0] n, input logic [15:0] d);
        @(negedge clk);
        reg_wr_en_i = 1'b1;
        reg_num_i   = n;
        reg_data_i  = d;
        @(negedge clk);                             // accepted on the edge in between
        reg_wr_en_i = 1'b0;
    endtask

    task automatic expect_reg(input logic [5:0] n, input logic [15:0] expected);
        @(negedge clk);
        reg_num_i = n;
        @(negedge clk);                             // read data is one cycle late
        check("reg_data_o", reg_data_o, expected);
    endtask

    always @(posedge clk) begin
        if (pf_line_addr_set_o) addr_sets <= addr_sets + 1;
    end

    // raster measurements, only edges seen while measuring count
    always @(negedge clk) begin
        if (measuring) begin
            cycle++;
            if (hsync_o && !hs_q) begin
                if (hs_at >= 0) check("hsync_o period", cycle - hs_at, 800);
                hs_at  = cycle;
                hs_len = 0;
            end
            if (hsync_o && hs_len >= 0) hs_len++;
            if (!hsync_o && hs_q && hs_len >= 0) check("hsync_o width", hs_len, 96);
            if (!h_blank_o && hb_q && hs_at >= 0) begin
                check("h_blank_o fall after hsync_o rise", cycle - hs_at, 144);
            end
            if (vsync_o && !vs_q) begin
                if (vs_at >= 0) check("vsync_o period", cycle - vs_at, FRAME_CYCLES);
                vs_at  = cycle;
                vs_len = 0;
                vs_rises++;
            end
            if (vsync_o && vs_len >= 0) vs_len++;
            if (!vsync_o && vs_q && vs_len >= 0) check("vsync_o width", vs_len, 1600);
            if (dv_de_o && !de_q) de_len = 0;
            if (dv_de_o && de_len >= 0) de_len++;
            if (!dv_de_o && de_q && de_len >= 0) begin
                check("dv_de_o cycles per line", de_len, 640);
                de_lines++;
            end
            if (mem_fetch_o && !fetch_q) fetch_len = 0;
            if (mem_fetch_o && fetch_len >= 0) fetch_len++;
            if (!mem_fetch_o && fetch_q && fetch_len >= 0) begin
                check("mem_fetch_o cycles per line", fetch_len, 696);
                fetch_lines++;
            end
            check("dv_de_o in vertical blank", dv_de_o & v_blank_o, 0);
            check("mem_fetch_o in vertical blank", mem_fetch_o & v_blank_o, 0);
            if (video_intr_o && !intr_q) begin
                if (intr_at >= 0) check("video_intr_o period", cycle - intr_at, FRAME_CYCLES);
                intr_at = cycle;
                intr_rises++;
            end
            if (!v_blank_o && vb_q) begin           // new frame starts
                de_lines    = 0;
                fetch_lines = 0;
                frame_ok    = 1'b1;
            end
            if (v_blank_o && !vb_q) begin
                check("video_intr_o at vblank start", video_intr_o, 1);
                if (frame_ok) begin
                    check("dv_de_o lines per frame", de_lines, 480);
                    check("mem_fetch_o lines per frame", fetch_lines, 480);
                    frames_checked++;
                end
            end
        end
        hs_q    = hsync_o;
        vs_q    = vsync_o;
        de_q    = dv_de_o;
        fetch_q = mem_fetch_o;
        vb_q    = v_blank_o;
        intr_q  = video_intr_o;
        hb_q    = h_blank_o;
    end

    initial begin
        #(WATCHDOG_CYCLES * 4);
        $display("watchdog expired before the test sequence finished");
        $display("Simulation FAILED");
        $fatal(1, "timeout");
    end

    initial begin
        reset_i     = 1'b1;
        reg_wr_en_i = 1'b0;
        reg_num_i   = '0;
        reg_data_i  = '0;
        repeat (10) @(negedge clk);
        reset_i = 1'b0;

        expect_reg(`XR_PA_GFX_CTRL, 16'h0080);      // blank set
        expect_reg(`XR_VID_RIGHT, 16'd640);
        expect_reg(`XR_VID_LEFT, 16'h0000);
        expect_reg(`XR_PA_LINE_LEN, 16'd80);
        expect_reg(`XR_VID_CTRL, 16'h0008);
        expect_reg(`XR_VID_HSIZE, 16'd640);
        expect_reg(`XR_VID_VSIZE, 16'd480);

        // two visible lines with the playfield still blanked
        repeat (1600) begin
            @(negedge clk);
            check("mem_fetch_o while blanked", mem_fetch_o, 0);
        end

        for (int i = 0; i < TABLE_LEN; i++) begin
            num  = table_entries[i][21:16];
            mask = table_entries[i][15:0];
            rng  = xorshift(rng);
            data = rng[15:0];
            sets_before = addr_sets;
            write_reg(num, data);
            case (num)
                `XR_VID_CTRL: begin
                    check("border_color_o", border_color_o, data[7:0]);
                end
                `XR_VID_INTR: begin
                    check("video_intr_o after write", video_intr_o, 1);
                end
                `XR_PA_GFX_CTRL: begin
                    check("pf_colorbase_o", pf_colorbase_o, data[15:8]);
                    check("pf_blank_o", pf_blank_o, data[7]);
                    check("pf_bitmap_o", pf_bitmap_o, data[6]);
                    check("pf_bpp_o", pf_bpp_o, data[5:4]);
                    check("pf_h_repeat_o", pf_h_repeat_o, data[3:2]);
                    check("pf_v_repeat_o", pf_v_repeat_o, data[1:0]);
                end
                `XR_PA_DISP_ADDR: begin
                    check("pf_start_addr_o", pf_start_addr_o, data);
                end
                `XR_PA_LINE_LEN: begin
                    check("pf_line_len_o", pf_line_len_o, data);
                end
                `XR_PA_HV_SCROLL: begin
                    check("pf_fine_hscroll_o", pf_fine_hscroll_o, data[12:8]);
                    check("pf_fine_vscroll_o", pf_fine_vscroll_o, data[5:0]);
                end
                `XR_PA_LINE_ADDR: begin
                    check("pf_line_addr_o", pf_line_addr_o, data);
                end
                default: begin
                end
            endcase
            expect_reg(num, data & mask);
            if (num == `XR_PA_LINE_ADDR) begin
                check("pf_line_addr_set_o pulses", addr_sets - sets_before, 1);
            end
        end

        write_reg(`XR_PA_GFX_CTRL, 16'h0000);       // unblank the playfield
        @(posedge clk);
        measuring = 1'b1;

        @(posedge vsync_o);
        @(negedge clk);
        reg_num_i = `XR_SCANLINE;
        @(negedge clk);
        check("SCANLINE at vsync", reg_data_o, 16'd490);

        wait (vs_rises >= 2);
        @(negedge clk);
        check("frames measured", frames_checked != 0, 1);
        check("interrupt pulses measured", intr_rises >= 2, 1);
        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+verilog
verilog/video_pkg.sv
verilog/video_reg_decode.sv
verilog/video_timing_exec.sv
verilog/video_reg_result.sv
verilog/video_gen.sv
sim/video_gen_properties.sv
sim/video_gen_tb.sv

// ==== verilog/video_defines.svh ====
// video core constants
`ifndef VIDEO_DEFINES_SVH
`define VIDEO_DEFINES_SVH

// 640x480 horizontal timing, in pixel clocks
`define H_FRONT_PORCH   16
`define H_SYNC_PULSE    96
`define H_BACK_PORCH    48
`define H_OFFSCREEN     (`H_FRONT_PORCH + `H_SYNC_PULSE + `H_BACK_PORCH)   // 160
`define H_VISIBLE       640
`define H_TOTAL         (`H_OFFSCREEN + `H_VISIBLE)                        // 800

// vertical timing, in lines
`define V_VISIBLE       480
`define V_FRONT_PORCH   10
`define V_SYNC_PULSE    2
`define V_BACK_PORCH    33
`define V_TOTAL         (`V_VISIBLE + `V_FRONT_PORCH + `V_SYNC_PULSE + `V_BACK_PORCH)

// playfield fetch window within a line
`define H_MEM_BEGIN     (`H_OFFSCREEN - 64)     // prefetch starts early
`define H_MEM_END       (`H_TOTAL - 8)          // and can stop a bit early

`define TILES_WIDE      80                      // default words per line
`define BORDER_RESET    8'h08                   // dark grey, shows the core is alive

// register numbers
`define XR_VID_CTRL     6'h00
`define XR_VID_INTR     6'h03
`define XR_VID_LEFT     6'h04
`define XR_VID_RIGHT    6'h05
`define XR_SCANLINE     6'h08
`define XR_VID_HSIZE    6'h0A
`define XR_VID_VSIZE    6'h0B
`define XR_PA_GFX_CTRL  6'h10
`define XR_PA_DISP_ADDR 6'h12
`define XR_PA_LINE_LEN  6'h13
`define XR_PA_HV_SCROLL 6'h14
`define XR_PA_LINE_ADDR 6'h16

`endif

// ==== verilog/video_gen.sv ====
// video generator top
`include "video_defines.svh"
`default_nettype none
`timescale 1ns/1ps

module video_gen (
    input  wire logic                  clk,
    input  wire logic                  reset_i,
    input  wire logic                  reg_wr_en_i,
    input  wire video_pkg::reg_num_t   reg_num_i,
    input  wire video_pkg::word_t      reg_data_i,
    output video_pkg::word_t           reg_data_o,
    output logic                       hsync_o,
    output logic                       vsync_o,
    output logic                       dv_de_o,
    output logic                       h_blank_o,
    output logic                       v_blank_o,
    output logic                       mem_fetch_o,
    output logic                       video_intr_o,
    output video_pkg::color_t          border_color_o,
    output logic                       pf_blank_o,
    output video_pkg::color_t          pf_colorbase_o,
    output logic                       pf_bitmap_o,
    output logic [1:0]                 pf_bpp_o,
    output logic [1:0]                 pf_h_repeat_o,
    output logic [1:0]                 pf_v_repeat_o,
    output video_pkg::word_t           pf_start_addr_o,
    output video_pkg::word_t           pf_line_len_o,
    output video_pkg::word_t           pf_line_addr_o,
    output logic [4:0]                 pf_fine_hscroll_o,
    output logic [5:0]                 pf_fine_vscroll_o,
    output logic                       pf_line_addr_set_o
);
    import video_pkg::*;

    hres_t vid_left;
    hres_t vid_right;
    vres_t v_count;                                 // for SCANLINE read
    logic  intr_req;                                // VID_INTR write

    video_reg_decode decode (
        .clk                (clk),
        .reset_i            (reset_i),
        .reg_wr_en_i        (reg_wr_en_i),
        .reg_num_i          (reg_num_i),
        .reg_data_i         (reg_data_i),
        .border_color_o     (border_color_o),
        .vid_left_o         (vid_left),
        .vid_right_o        (vid_right),
        .intr_req_o         (intr_req),
        .pf_blank_o         (pf_blank_o),
        .pf_colorbase_o     (pf_colorbase_o),
        .pf_bitmap_o        (pf_bitmap_o),
        .pf_bpp_o           (pf_bpp_o),
        .pf_h_repeat_o      (pf_h_repeat_o),
        .pf_v_repeat_o      (pf_v_repeat_o),
        .pf_start_addr_o    (pf_start_addr_o),
        .pf_line_len_o      (pf_line_len_o),
        .pf_line_addr_o     (pf_line_addr_o),
        .pf_fine_hscroll_o  (pf_fine_hscroll_o),
        .pf_fine_vscroll_o  (pf_fine_vscroll_o),
        .pf_line_addr_set_o (pf_line_addr_set_o)
    );

    video_timing_exec execute (
        .clk          (clk),
        .reset_i      (reset_i),
        .pf_blank_i   (pf_blank_o),
        .intr_req_i   (intr_req),
        .v_count_o    (v_count),
        .hsync_o      (hsync_o),
        .vsync_o      (vsync_o),
        .dv_de_o      (dv_de_o),
        .h_blank_o    (h_blank_o),
        .v_blank_o    (v_blank_o),
        .mem_fetch_o  (mem_fetch_o),
        .video_intr_o (video_intr_o)
    );

    video_reg_result result (
        .clk               (clk),
        .reg_num_i         (reg_num_i),
        .v_count_i         (v_count),
        .border_color_i    (border_color_o),
        .vid_left_i        (vid_left),
        .vid_right_i       (vid_right),
        .pf_blank_i        (pf_blank_o),
        .pf_colorbase_i    (pf_colorbase_o),
        .pf_bitmap_i       (pf_bitmap_o),
        .pf_bpp_i          (pf_bpp_o),
        .pf_h_repeat_i     (pf_h_repeat_o),
        .pf_v_repeat_i     (pf_v_repeat_o),
        .pf_start_addr_i   (pf_start_addr_o),
        .pf_line_len_i     (pf_line_len_o),
        .pf_line_addr_i    (pf_line_addr_o),
        .pf_fine_hscroll_i (pf_fine_hscroll_o),
        .pf_fine_vscroll_i (pf_fine_vscroll_o),
        .reg_data_o        (reg_data_o)
    );

endmodule

`default_nettype wire

// ==== verilog/video_pkg.sv ====
// video core types
`default_nettype none

package video_pkg;

    // register data word, also a memory word address
    typedef logic [15:0] word_t;

    // horizontal pixel count, up to 1023
    typedef logic [9:0] hres_t;

    // vertical line count, up to 1023
    typedef logic [9:0] vres_t;

    // palette index
    typedef logic [7:0] color_t;

    // register number on the write and read port
    typedef logic [5:0] reg_num_t;

endpackage

`default_nettype wire

// ==== verilog/video_reg_decode.sv ====
// video register write decode
`include "video_defines.svh"
`default_nettype none
`timescale 1ns/1ps

module video_reg_decode (
    input  wire logic                  clk,
    input  wire logic                  reset_i,
    input  wire logic                  reg_wr_en_i,
    input  wire video_pkg::reg_num_t   reg_num_i,
    input  wire video_pkg::word_t      reg_data_i,
    output video_pkg::color_t          border_color_o,
    output video_pkg::hres_t           vid_left_o,
    output video_pkg::hres_t           vid_right_o,
    output logic                       intr_req_o,
    output logic                       pf_blank_o,
    output video_pkg::color_t          pf_colorbase_o,
    output logic                       pf_bitmap_o,
    output logic [1:0]                 pf_bpp_o,
    output logic [1:0]                 pf_h_repeat_o,
    output logic [1:0]                 pf_v_repeat_o,
    output video_pkg::word_t           pf_start_addr_o,
    output video_pkg::word_t           pf_line_len_o,
    output video_pkg::word_t           pf_line_addr_o,
    output logic [4:0]                 pf_fine_hscroll_o,
    output logic [5:0]                 pf_fine_vscroll_o,
    output logic                       pf_line_addr_set_o
);
    import video_pkg::*;

    reg_num_t wr_num;                               // number of the register being written

    assign wr_num = reg_wr_en_i ? reg_num_i : 6'h3F;    // 3F has no register behind it

    // interrupt request goes straight to the timing block, which registers it
    assign intr_req_o = (wr_num == `XR_VID_INTR);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            border_color_o     <= `BORDER_RESET;
            vid_left_o         <= '0;
            vid_right_o        <= hres_t'(`H_VISIBLE);
            pf_blank_o         <= 1'b1;             // playfield starts blanked
            pf_colorbase_o     <= '0;
            pf_bitmap_o        <= 1'b0;
            pf_bpp_o           <= '0;
            pf_h_repeat_o      <= '0;
            pf_v_repeat_o      <= '0;
            pf_start_addr_o    <= '0;
            pf_line_len_o      <= word_t'(`TILES_WIDE);
            pf_line_addr_o     <= '0;
            pf_fine_hscroll_o  <= '0;
            pf_fine_vscroll_o  <= '0;
            pf_line_addr_set_o <= 1'b0;
        end else begin
            pf_line_addr_set_o <= 1'b0;             // strobe lasts one cycle
            case (wr_num)
                `XR_VID_CTRL: begin
                    border_color_o <= reg_data_i[7:0];
                end
                `XR_VID_LEFT: begin
                    vid_left_o <= reg_data_i[9:0];
                end
                `XR_VID_RIGHT: begin
                    vid_right_o <= reg_data_i[9:0];
                end
                `XR_PA_GFX_CTRL: begin
                    pf_colorbase_o <= reg_data_i[15:8];
                    pf_blank_o     <= reg_data_i[7];
                    pf_bitmap_o    <= reg_data_i[6];
                    pf_bpp_o       <= reg_data_i[5:4];
                    pf_h_repeat_o  <= reg_data_i[3:2];
                    pf_v_repeat_o  <= reg_data_i[1:0];
                end
                `XR_PA_DISP_ADDR: begin
                    pf_start_addr_o <= reg_data_i;
                end
                `XR_PA_LINE_LEN: begin
                    pf_line_len_o <= reg_data_i;
                end
                `XR_PA_HV_SCROLL: begin
                    pf_fine_hscroll_o <= reg_data_i[12:8];
                    pf_fine_vscroll_o <= reg_data_i[5:0];
                end
                `XR_PA_LINE_ADDR: begin
                    pf_line_addr_o     <= reg_data_i;
                    pf_line_addr_set_o <= 1'b1;     // playfield reloads its line address
                end
                default: begin
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== verilog/video_reg_result.sv ====
// register read-back
`include "video_defines.svh"
`default_nettype none
`timescale 1ns/1ps

module video_reg_result (
    input  wire logic                  clk,
    input  wire video_pkg::reg_num_t   reg_num_i,
    input  wire video_pkg::vres_t      v_count_i,
    input  wire video_pkg::color_t     border_color_i,
    input  wire video_pkg::hres_t      vid_left_i,
    input  wire video_pkg::hres_t      vid_right_i,
    input  wire logic                  pf_blank_i,
    input  wire video_pkg::color_t     pf_colorbase_i,
    input  wire logic                  pf_bitmap_i,
    input  wire logic [1:0]            pf_bpp_i,
    input  wire logic [1:0]            pf_h_repeat_i,
    input  wire logic [1:0]            pf_v_repeat_i,
    input  wire video_pkg::word_t      pf_start_addr_i,
    input  wire video_pkg::word_t      pf_line_len_i,
    input  wire video_pkg::word_t      pf_line_addr_i,
    input  wire logic [4:0]            pf_fine_hscroll_i,
    input  wire logic [5:0]            pf_fine_vscroll_i,
    output video_pkg::word_t           reg_data_o
);
    import video_pkg::*;

    word_t rd_vid;                                  // video control group
    word_t rd_pf;                                   // playfield A group

    always_comb begin
        case (reg_num_i[3:0])
            4'(`XR_VID_CTRL):  rd_vid = {8'h00, border_color_i};
            4'(`XR_VID_LEFT):  rd_vid = 16'(vid_left_i);
            4'(`XR_VID_RIGHT): rd_vid = 16'(vid_right_i);
            4'(`XR_SCANLINE):  rd_vid = 16'(v_count_i);
            4'(`XR_VID_HSIZE): rd_vid = 16'(`H_VISIBLE);
            4'(`XR_VID_VSIZE): rd_vid = 16'(`V_VISIBLE);
            default:           rd_vid = '0;        // VID_INTR is write only
        endcase
    end

    always_comb begin
        case (reg_num_i[3:0])
            4'(`XR_PA_GFX_CTRL):  rd_pf = {pf_colorbase_i, pf_blank_i, pf_bitmap_i,
                                           pf_bpp_i, pf_h_repeat_i, pf_v_repeat_i};
            4'(`XR_PA_DISP_ADDR): rd_pf = pf_start_addr_i;
            4'(`XR_PA_LINE_LEN):  rd_pf = pf_line_len_i;
            4'(`XR_PA_HV_SCROLL): rd_pf = {3'b000, pf_fine_hscroll_i, 2'b00, pf_fine_vscroll_i};
            4'(`XR_PA_LINE_ADDR): rd_pf = pf_line_addr_i;
            default:              rd_pf = '0;
        endcase
    end

    // nothing lives above 0x1F
    always_ff @(posedge clk) begin
        if (reg_num_i[5]) begin
            reg_data_o <= '0;
        end else begin
            reg_data_o <= reg_num_i[4] ? rd_pf : rd_vid;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/video_timing_exec.sv ====
// raster timing and fetch window
`include "video_defines.svh"
`default_nettype none
`timescale 1ns/1ps

module video_timing_exec (
    input  wire logic          clk,
    input  wire logic          reset_i,
    input  wire logic          pf_blank_i,
    input  wire logic          intr_req_i,
    output video_pkg::vres_t   v_count_o,
    output logic               hsync_o,
    output logic               vsync_o,
    output logic               dv_de_o,
    output logic               h_blank_o,
    output logic               v_blank_o,
    output logic               mem_fetch_o,
    output logic               video_intr_o
);
    import video_pkg::*;

    hres_t h_count;
    vres_t v_count;
    logic  end_of_line;
    logic  end_of_frame;
    logic  end_of_visible;
    logic  h_visible;
    logic  v_visible;
    logic  mem_fetch;                               // fetch window, before blank gating
    logic  mem_fetch_next;

    assign end_of_line    = (h_count == hres_t'(`H_TOTAL - 1));
    assign end_of_frame   = end_of_line && (v_count == vres_t'(`V_TOTAL - 1));
    assign end_of_visible = end_of_line && (v_count == vres_t'(`V_VISIBLE - 1));

    assign h_visible = (h_count >= hres_t'(`H_OFFSCREEN));    // border and sync come first
    assign v_visible = (v_count < vres_t'(`V_VISIBLE));

    assign hsync_o   = (h_count >= hres_t'(`H_FRONT_PORCH)) &&
                       (h_count < hres_t'(`H_FRONT_PORCH + `H_SYNC_PULSE));
    assign vsync_o   = (v_count >= vres_t'(`V_VISIBLE + `V_FRONT_PORCH)) &&
                       (v_count < vres_t'(`V_VISIBLE + `V_FRONT_PORCH + `V_SYNC_PULSE));
    assign dv_de_o   = h_visible && v_visible;
    assign h_blank_o = ~h_visible;
    assign v_blank_o = ~v_visible;
    assign v_count_o = v_count;

    // open at H_MEM_BEGIN, hold until H_MEM_END, only on visible lines
    assign mem_fetch_next = (mem_fetch ? (h_count != hres_t'(`H_MEM_END))
                                       : (h_count == hres_t'(`H_MEM_BEGIN))) && v_visible;
    assign mem_fetch_o    = mem_fetch && !pf_blank_i;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            h_count      <= '0;
            v_count      <= '0;
            mem_fetch    <= 1'b0;
            video_intr_o <= 1'b0;
        end else begin
            mem_fetch    <= mem_fetch_next;
            video_intr_o <= end_of_visible || intr_req_i;   // vblank start or forced by write
            if (end_of_line) begin
                h_count <= '0;
                if (end_of_frame) begin
                    v_count <= '0;
                end else begin
                    v_count <= v_count + 1'b1;
                end
            end else begin
                h_count <= h_count + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire
